/* common/ex_pkg.sv */
package ex_pkg;

    // instruction op codes, as decoded upstream
    typedef enum logic [7:0] {
        OP_LD        = 8'h00,
        OP_LDU,
        OP_LL,
        OP_ST,
        OP_SC,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_MUL,
        OP_MULH,
        OP_MULHU,
        OP_DIV,
        OP_MOD,
        OP_DIVU,
        OP_MODU,
        OP_LU12I,
        OP_PCADDU12I,
        OP_BL,
        OP_JIRL,
        OP_ERTN,
        OP_BREAK,
        OP_SYSCALL,
        OP_CACOP
    } op_t;

    // instruction class
    typedef enum logic [3:0] {
        OP_TYPE_3R     = 4'h0,
        OP_TYPE_2RI12,
        OP_TYPE_BJ,
        OP_TYPE_ATOMIC,
        OP_TYPE_CSR,
        OP_TYPE_U12I,
        OP_TYPE_RDCNT
    } op_type_t;

    typedef enum logic [1:0] {
        ACCESS_SZ_BYTE = 2'd0,
        ACCESS_SZ_HALF = 2'd1,
        ACCESS_SZ_WORD = 2'd2
    } access_sz_t;

    // internal alu function, decoded from op_t
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // one executed instruction on its way to the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        access_sz_t  access_sz;
        logic        mm_re;
        logic        mm_we;
        logic        reg_wen;
        logic        ale;
        logic        ertn;
    } ex_rec_t;

    localparam int MUL_STAGES_DEFAULT = 2;

endpackage

/* common/ex_mm_if.sv */
interface ex_mm_if;
    import ex_pkg::*;

    // record from execute, stall back from the pipeline register
    ex_rec_t rec;
    logic    stall;

    modport producer (
        output rec,
        input  stall
    );

    modport buffer (
        input  rec,
        output stall
    );

endinterface

/* execute/ex_alu.sv */
module ex_alu (
    input  ex_pkg::op_t op,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    output logic [31:0] alu_out
);
    import ex_pkg::*;

    alu_op_t alu_op;

    // everything not listed uses the adder (loads, stores, branches)
    always_comb begin
        case (op)
            OP_SUB:  alu_op = ALU_SUB;
            OP_SLT:  alu_op = ALU_SLT;
            OP_SLTU: alu_op = ALU_SLTU;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_SLL:  alu_op = ALU_SLL;
            OP_SRL:  alu_op = ALU_SRL;
            OP_SRA:  alu_op = ALU_SRA;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_out = src_a - src_b;
            ALU_SLT:  alu_out = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: alu_out = {31'b0, src_a < src_b};
            ALU_AND:  alu_out = src_a & src_b;
            ALU_OR:   alu_out = src_a | src_b;
            ALU_XOR:  alu_out = src_a ^ src_b;
            // shift amount is the low five bits
            ALU_SLL:  alu_out = src_a << src_b[4:0];
            ALU_SRL:  alu_out = src_a >> src_b[4:0];
            ALU_SRA:  alu_out = $unsigned($signed(src_a) >>> src_b[4:0]);
            default:  alu_out = src_a + src_b;
        endcase
    end

endmodule

/* execute/ex_muldiv.sv */
module ex_muldiv #(
    parameter int MUL_STAGES = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  ex_pkg::op_t op,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    output logic        busy,
    output logic [31:0] mul_out,
    output logic        mul_done,
    output logic [31:0] div_out,
    output logic        div_done
);
    import ex_pkg::*;

    logic                  mul_start;
    logic                  mul_signed;
    logic signed [65:0]    prod_full;
    logic [63:0]           prod_q [MUL_STAGES];
    logic [MUL_STAGES-1:0] mul_v_q;
    logic [MUL_STAGES-1:0] mul_hi_q;

    logic        div_start;
    logic        div_signed;
    logic [31:0] abs_a;
    logic [31:0] abs_b;
    logic        div_busy_q;
    logic [5:0]  div_cnt_q;
    logic [31:0] quo_q;
    logic [31:0] rem_q;
    logic [31:0] dvsr_q;
    logic [31:0] dvnd_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        want_rem_q;
    logic        by_zero_q;
    logic [32:0] shifted;
    logic [33:0] diff;
    logic [31:0] quo_fix;
    logic [31:0] rem_fix;

    assign mul_start  = start && (op inside {OP_MUL, OP_MULH, OP_MULHU});
    assign div_start  = start && (op inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU});

    // low word is identical signed or unsigned, only mulh needs sign extension
    assign mul_signed = (op == OP_MULH);
    assign prod_full  = $signed({mul_signed & src_a[31], src_a})
                      * $signed({mul_signed & src_b[31], src_b});

    always_ff @(posedge clk) begin
        prod_q[0]   <= prod_full[63:0];
        mul_hi_q[0] <= (op != OP_MUL);
        for (int i = 1; i < MUL_STAGES; i++) begin
            prod_q[i]   <= prod_q[i-1];
            mul_hi_q[i] <= mul_hi_q[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mul_v_q <= '0;
        end else begin
            mul_v_q <= (mul_v_q << 1) | MUL_STAGES'(mul_start);
        end
    end

    assign mul_done = mul_v_q[MUL_STAGES-1];
    assign mul_out  = mul_hi_q[MUL_STAGES-1] ? prod_q[MUL_STAGES-1][63:32]
                                             : prod_q[MUL_STAGES-1][31:0];

    // restoring divider works on magnitudes
    assign div_signed = op inside {OP_DIV, OP_MOD};
    assign abs_a      = (div_signed && src_a[31]) ? -src_a : src_a;
    assign abs_b      = (div_signed && src_b[31]) ? -src_b : src_b;
    assign shifted    = {rem_q, quo_q[31]};
    assign diff       = {1'b0, shifted} - {2'b0, dvsr_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            div_busy_q <= 1'b0;
            div_cnt_q  <= '0;
            div_done   <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                div_busy_q <= 1'b1;
                div_cnt_q  <= '0;
            end else if (div_busy_q) begin
                div_cnt_q <= div_cnt_q + 6'd1;
                // last of 32 steps
                if (div_cnt_q == 6'd31) begin
                    div_busy_q <= 1'b0;
                    div_done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            rem_q      <= '0;
            quo_q      <= abs_a;
            dvsr_q     <= abs_b;
            dvnd_q     <= src_a;
            neg_quo_q  <= div_signed && (src_a[31] ^ src_b[31]);
            neg_rem_q  <= div_signed && src_a[31];
            want_rem_q <= op inside {OP_MOD, OP_MODU};
            by_zero_q  <= (src_b == 32'd0);
        end else if (div_busy_q) begin
            if (!diff[33]) begin
                rem_q <= diff[31:0];
                quo_q <= {quo_q[30:0], 1'b1};
            end else begin
                rem_q <= shifted[31:0];
                quo_q <= {quo_q[30:0], 1'b0};
            end
        end
    end

    // sign correction, divide by zero gives all ones and the dividend
    assign quo_fix = by_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fix = by_zero_q ? dvnd_q : (neg_rem_q ? -rem_q : rem_q);
    assign div_out = want_rem_q ? rem_fix : quo_fix;

    // low in the cycle a result is presented
    assign busy = div_busy_q || ((mul_v_q != '0) && !mul_done);

endmodule

/* execute/ex_ctrl.sv */
module ex_ctrl #(
    parameter int MUL_STAGES = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_valid,
    output logic               issue_allow,
    input  ex_pkg::op_t        op,
    input  ex_pkg::op_type_t   op_type,
    input  ex_pkg::access_sz_t access_sz,
    input  logic [31:0]        src_a,
    input  logic [31:0]        src_b,
    input  logic [31:0]        st_data,
    input  logic [31:0]        pc,
    input  logic [19:0]        u12imm,
    ex_mm_if.producer          ex
);
    import ex_pkg::*;

    op_t         op_q;
    op_type_t    type_q;
    access_sz_t  sz_q;
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] st_q;
    logic [31:0] pc_q;
    logic [19:0] imm_q;
    logic [31:0] res_q;
    logic        ex_valid_q;
    logic        start_q;
    logic        done_q;
    logic        ready_q;

    logic [31:0] alu_out;
    logic [31:0] mul_out;
    logic [31:0] div_out;
    logic [31:0] md_out;
    logic [31:0] exe_out;
    logic        mul_done;
    logic        div_done;
    logic        md_busy;
    logic        md_done;
    logic        is_mul;
    logic        is_div;
    logic        complete;
    logic        leave;
    logic        accept;
    logic        mm_re;
    logic        mm_we;
    logic        reg_wen;
    logic        ale;

    ex_alu u_alu (
        .op      (op_q),
        .src_a   (a_q),
        .src_b   (b_q),
        .alu_out (alu_out)
    );

    ex_muldiv #(
        .MUL_STAGES (MUL_STAGES)
    ) u_muldiv (
        .clk      (clk),
        .reset    (reset),
        .start    (start_q),
        .op       (op_q),
        .src_a    (a_q),
        .src_b    (b_q),
        .busy     (md_busy),
        .mul_out  (mul_out),
        .mul_done (mul_done),
        .div_out  (div_out),
        .div_done (div_done)
    );

    assign is_mul   = op_q inside {OP_MUL, OP_MULH, OP_MULHU};
    assign is_div   = op_q inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU};
    assign md_done  = is_mul ? mul_done : div_done;
    assign md_out   = is_mul ? mul_out : div_out;

    // done_q keeps a finished mul/div result while the buffer stalls
    assign complete = ex_valid_q && (!(is_mul || is_div) || md_done || done_q);
    assign leave    = complete && !ex.stall;

    assign issue_allow = ready_q && !md_busy && !ex.stall && (!ex_valid_q || complete);
    assign accept      = issue_valid && issue_allow;

    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q    <= 1'b0;
            ex_valid_q <= 1'b0;
            start_q    <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            start_q <= accept;
            if (accept) begin
                ex_valid_q <= 1'b1;
            end else if (leave) begin
                ex_valid_q <= 1'b0;
            end
            if (accept || leave) begin
                done_q <= 1'b0;
            end else if (md_done) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            type_q <= op_type;
            sz_q   <= access_sz;
            a_q    <= src_a;
            b_q    <= src_b;
            st_q   <= st_data;
            pc_q   <= pc;
            imm_q  <= u12imm;
        end
        if (md_done) begin
            res_q <= md_out;
        end
    end

    always_comb begin
        case (op_q)
            OP_LU12I:                         exe_out = {imm_q, 12'b0};
            OP_PCADDU12I:                     exe_out = pc_q + {imm_q, 12'b0};
            OP_BL, OP_JIRL:                   exe_out = pc_q + 32'd4;
            OP_MUL, OP_MULH, OP_MULHU,
            OP_DIV, OP_MOD, OP_DIVU, OP_MODU: exe_out = done_q ? res_q : md_out;
            default:                          exe_out = alu_out;
        endcase
    end

    assign mm_re = op_q inside {OP_LD, OP_LDU, OP_LL};
    assign mm_we = op_q inside {OP_ST, OP_SC};

    // write enable by instruction class
    assign reg_wen = (type_q == OP_TYPE_3R && !(op_q inside {OP_BREAK, OP_SYSCALL}))
                  || (type_q == OP_TYPE_2RI12 && !(op_q inside {OP_ST, OP_CACOP}))
                  || (type_q == OP_TYPE_BJ && (op_q inside {OP_JIRL, OP_BL}))
                  || (type_q == OP_TYPE_ATOMIC && op_q == OP_LL)
                  || (type_q == OP_TYPE_CSR)
                  || (type_q == OP_TYPE_U12I)
                  || (type_q == OP_TYPE_RDCNT);

    always_comb begin
        ale = 1'b0;
        if (mm_re || mm_we) begin
            case (sz_q)
                ACCESS_SZ_WORD: ale = |alu_out[1:0];
                ACCESS_SZ_HALF: ale = alu_out[0];
                default:        ale = 1'b0;
            endcase
        end
    end

    always_comb begin
        ex.rec = '{
            valid:     complete,
            result:    exe_out,
            mem_addr:  alu_out,
            mem_wdata: st_q,
            access_sz: sz_q,
            mm_re:     mm_re,
            mm_we:     mm_we,
            reg_wen:   reg_wen,
            ale:       ale,
            ertn:      (op_q == OP_ERTN)
        };
    end

endmodule

/* rtl/ex_mm_reg.sv */
module ex_mm_reg (
    input  logic            clk,
    input  logic            reset,
    ex_mm_if.buffer         ex,
    input  logic            mem_ready,
    output ex_pkg::ex_rec_t rec_out
);
    import ex_pkg::*;

    ex_rec_t data_q;
    logic    valid_q;
    logic    mem_op;

    // misaligned entries never issue a request, so they never wait
    assign mem_op   = (data_q.mm_re || data_q.mm_we) && !data_q.ale;
    assign ex.stall = valid_q && mem_op && !mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (!ex.stall) begin
            valid_q <= ex.rec.valid;
        end
    end

    // load when empty or draining
    always_ff @(posedge clk) begin
        if (!ex.stall && ex.rec.valid) begin
            data_q <= ex.rec;
        end
    end

    always_comb begin
        rec_out       = data_q;
        rec_out.valid = valid_q;
    end

endmodule

/* rtl/mem_req.sv */
module mem_req (
    input  ex_pkg::ex_rec_t    rec_in,
    input  logic               mem_ready,
    output logic               mem_req,
    output logic               mem_we,
    output logic [31:0]        mem_addr,
    output logic [3:0]         mem_wstrb,
    output logic [31:0]        mem_wdata,
    output ex_pkg::access_sz_t mem_sz,
    output logic               wb_valid,
    output logic               wb_wen,
    output logic [31:0]        wb_result,
    output logic               wb_ale,
    output logic               wb_ertn
);
    import ex_pkg::*;

    logic       is_mem;
    logic [1:0] lane;

    assign is_mem = rec_in.mm_re || rec_in.mm_we;
    assign lane   = rec_in.mem_addr[1:0];

    assign mem_req   = rec_in.valid && is_mem && !rec_in.ale;
    assign mem_we    = mem_req && rec_in.mm_we;
    assign mem_addr  = rec_in.mem_addr;
    assign mem_sz    = rec_in.access_sz;

    // store data moved onto the addressed byte lane
    assign mem_wdata = rec_in.mem_wdata << {lane, 3'b000};

    always_comb begin
        case (rec_in.access_sz)
            ACCESS_SZ_BYTE: mem_wstrb = 4'b0001 << lane;
            ACCESS_SZ_HALF: mem_wstrb = 4'b0011 << lane;
            default:        mem_wstrb = 4'b1111;
        endcase
    end

    // entry retires when it leaves the buffer
    assign wb_valid  = rec_in.valid && (!mem_req || mem_ready);
    assign wb_wen    = wb_valid && rec_in.reg_wen;
    assign wb_result = rec_in.result;
    assign wb_ale    = rec_in.valid && rec_in.ale;
    assign wb_ertn   = rec_in.valid && rec_in.ertn;

endmodule

/* rtl/ex_top.sv */
module ex_top #(
    parameter int MUL_STAGES = ex_pkg::MUL_STAGES_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_valid,
    output logic               issue_allow,
    input  ex_pkg::op_t        op,
    input  ex_pkg::op_type_t   op_type,
    input  ex_pkg::access_sz_t access_sz,
    input  logic [31:0]        src_a,
    input  logic [31:0]        src_b,
    input  logic [31:0]        st_data,
    input  logic [31:0]        pc,
    input  logic [19:0]        u12imm,
    output logic               mem_req,
    output logic               mem_we,
    output logic [31:0]        mem_addr,
    output logic [3:0]         mem_wstrb,
    output logic [31:0]        mem_wdata,
    output ex_pkg::access_sz_t mem_sz,
    input  logic               mem_ready,
    output logic               wb_valid,
    output logic               wb_wen,
    output logic [31:0]        wb_result,
    output logic               wb_ale,
    output logic               wb_ertn
);
    import ex_pkg::*;

    ex_rec_t mm_rec;

    ex_mm_if ex_if ();

    ex_ctrl #(
        .MUL_STAGES (MUL_STAGES)
    ) u_ex_ctrl (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_allow (issue_allow),
        .op          (op),
        .op_type     (op_type),
        .access_sz   (access_sz),
        .src_a       (src_a),
        .src_b       (src_b),
        .st_data     (st_data),
        .pc          (pc),
        .u12imm      (u12imm),
        .ex          (ex_if.producer)
    );

    ex_mm_reg u_ex_mm_reg (
        .clk       (clk),
        .reset     (reset),
        .ex        (ex_if.buffer),
        .mem_ready (mem_ready),
        .rec_out   (mm_rec)
    );

    mem_req u_mem_req (
        .rec_in    (mm_rec),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .mem_sz    (mem_sz),
        .wb_valid  (wb_valid),
        .wb_wen    (wb_wen),
        .wb_result (wb_result),
        .wb_ale    (wb_ale),
        .wb_ertn   (wb_ertn)
    );

endmodule

/* test/ex_assertions.sv */
module ex_assertions (
    input logic       clk,
    input logic       reset,
    input logic       issue_allow,
    input logic       mem_req,
    input logic       mem_ready,
    input logic       wb_ale,
    input logic [3:0] mem_wstrb
);
    timeunit 1ns;
    timeprecision 100ps;

    // a request without mem_ready is exactly the buffer stall
    stall_blocks_issue: assert property (
        @(posedge clk) disable iff (reset) (mem_req && !mem_ready) |-> !issue_allow
    ) else $error("issue_allow high while the buffer stalls");

    no_req_on_ale: assert property (
        @(posedge clk) disable iff (reset) wb_ale |-> !mem_req
    ) else $error("mem_req high for a misaligned access");

    strobe_on_req: assert property (
        @(posedge clk) disable iff (reset) mem_req |-> (mem_wstrb != 4'b0000)
    ) else $error("mem_req high with an empty byte strobe");

endmodule

bind ex_top ex_assertions u_assertions (
    .clk         (clk),
    .reset       (reset),
    .issue_allow (issue_allow),
    .mem_req     (mem_req),
    .mem_ready   (mem_ready),
    .wb_ale      (wb_ale),
    .mem_wstrb   (mem_wstrb)
);

/* test/ex_tb.sv */
module ex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import ex_pkg::*;

    localparam int N_TESTS    = 6;
    localparam int N_INSTR    = 200;
    localparam int CLK_PERIOD = 100;

    localparam op_t ALU_OPS [16] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
                                     OP_SLL, OP_SRL, OP_SRA, OP_LU12I, OP_PCADDU12I, OP_BL,
                                     OP_JIRL, OP_BREAK, OP_SYSCALL};
    localparam op_t MUL_OPS [3]  = '{OP_MUL, OP_MULH, OP_MULHU};
    localparam op_t DIV_OPS [4]  = '{OP_DIV, OP_MOD, OP_DIVU, OP_MODU};
    localparam op_t MEM_OPS [5]  = '{OP_LD, OP_LDU, OP_LL, OP_ST, OP_SC};
    localparam logic [31:0] EDGE_VALUES [6] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                                32'h8000_0000, 32'h7fff_ffff, 32'hffff_fffe};

    // expected writeback and memory request of one instruction
    typedef struct {
        logic [31:0] result;
        bit          chk_result;
        bit          wen;
        bit          mem;
        bit          we;
        logic [31:0] addr;
        access_sz_t  sz;
        logic [3:0]  strb;
        logic [31:0] wdata;
        bit          ale;
        bit          ertn;
    } wb_exp_t;

    logic        clk;
    logic        reset;
    logic        issue_valid;
    logic        issue_allow;
    op_t         op;
    op_type_t    op_type;
    access_sz_t  access_sz;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] st_data;
    logic [31:0] pc;
    logic [19:0] u12imm;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [3:0]  mem_wstrb;
    logic [31:0] mem_wdata;
    access_sz_t  mem_sz;
    logic        mem_ready;
    logic        wb_valid;
    logic        wb_wen;
    logic [31:0] wb_result;
    logic        wb_ale;
    logic        wb_ertn;

    logic [31:0] seed = 32'h2192_806e;
    int          errors = 0;
    int          total_instr = 0;
    wb_exp_t     exp_q [$];

    ex_top #(
        .MUL_STAGES (MUL_STAGES_DEFAULT)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_allow (issue_allow),
        .op          (op),
        .op_type     (op_type),
        .access_sz   (access_sz),
        .src_a       (src_a),
        .src_b       (src_b),
        .st_data     (st_data),
        .pc          (pc),
        .u12imm      (u12imm),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wstrb   (mem_wstrb),
        .mem_wdata   (mem_wdata),
        .mem_sz      (mem_sz),
        .mem_ready   (mem_ready),
        .wb_valid    (wb_valid),
        .wb_wen      (wb_wen),
        .wb_result   (wb_result),
        .wb_ale      (wb_ale),
        .wb_ertn     (wb_ertn)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    // corner values now and then for the mul and div tests
    function automatic logic [31:0] pick_operand(bit extremes);
        if (extremes && rand_below(3) == 0) begin
            return EDGE_VALUES[rand_below(6)];
        end
        return lcg_next();
    endfunction

    function automatic op_type_t class_of(op_t o);
        case (o)
            OP_LD, OP_LDU, OP_ST, OP_CACOP: return OP_TYPE_2RI12;
            OP_LL, OP_SC:                   return OP_TYPE_ATOMIC;
            OP_LU12I, OP_PCADDU12I:         return OP_TYPE_U12I;
            OP_BL, OP_JIRL, OP_ERTN:        return OP_TYPE_BJ;
            default:                        return OP_TYPE_3R;
        endcase
    endfunction

    function automatic wb_exp_t model_wb(op_t o, op_type_t t, access_sz_t sz,
                                         logic [31:0] a, logic [31:0] b, logic [31:0] st,
                                         logic [31:0] pc_v, logic [19:0] imm);
        wb_exp_t            e;
        logic signed [63:0] sp;
        logic [63:0]        up;
        longint             sa;
        longint             sb;
        longint             ua;
        longint             ub;
        int                 off;
        int                 nbytes;
        sa     = $signed(a);
        sb     = $signed(b);
        ua     = {32'b0, a};
        ub     = {32'b0, b};
        sp     = sa * sb;
        up     = {32'b0, a} * {32'b0, b};
        e.addr = a + b;
        off    = int'(e.addr[1:0]);
        case (o)
            OP_SUB:         e.result = a - b;
            OP_SLT:         e.result = {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:        e.result = {31'b0, a < b};
            OP_AND:         e.result = a & b;
            OP_OR:          e.result = a | b;
            OP_XOR:         e.result = a ^ b;
            OP_SLL:         e.result = a << b[4:0];
            OP_SRL:         e.result = a >> b[4:0];
            OP_SRA:         e.result = $signed(a) >>> b[4:0];
            OP_LU12I:       e.result = {imm, 12'b0};
            OP_PCADDU12I:   e.result = pc_v + {imm, 12'b0};
            OP_BL, OP_JIRL: e.result = pc_v + 32'd4;
            OP_MUL:         e.result = up[31:0];
            OP_MULH:        e.result = sp[63:32];
            OP_MULHU:       e.result = up[63:32];
            default:        e.result = e.addr;
        endcase
        if (o inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU}) begin
            if (b == 32'd0) begin
                e.result = (o inside {OP_DIV, OP_DIVU}) ? 32'hffff_ffff : a;
            end else begin
                case (o)
                    OP_DIV:  e.result = 32'(sa / sb);
                    OP_MOD:  e.result = 32'(sa % sb);
                    OP_DIVU: e.result = 32'(ua / ub);
                    default: e.result = 32'(ua % ub);
                endcase
            end
        end
        case (t)
            OP_TYPE_3R:     e.wen = !(o inside {OP_BREAK, OP_SYSCALL});
            OP_TYPE_2RI12:  e.wen = !(o inside {OP_ST, OP_CACOP});
            OP_TYPE_BJ:     e.wen = o inside {OP_BL, OP_JIRL};
            OP_TYPE_ATOMIC: e.wen = (o == OP_LL);
            default:        e.wen = 1'b1;
        endcase
        e.mem  = o inside {OP_LD, OP_LDU, OP_LL, OP_ST, OP_SC};
        e.we   = o inside {OP_ST, OP_SC};
        e.sz   = sz;
        e.ale  = e.mem && ((sz == ACCESS_SZ_HALF && off[0]) || (sz == ACCESS_SZ_WORD && off != 0));
        e.ertn = (o == OP_ERTN);
        e.chk_result = e.wen && !e.mem;
        // store data and strobes sit on the byte lanes of the address
        e.wdata = st << (8 * off);
        nbytes  = (sz == ACCESS_SZ_BYTE) ? 1 : ((sz == ACCESS_SZ_HALF) ? 2 : 4);
        for (int i = 0; i < 4; i++) begin
            e.strb[i] = (i >= off) && (i < off + nbytes);
        end
        return e;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_retire();
        wb_exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("writeback at %0t with no instruction outstanding", $time);
        end else begin
            e = exp_q.pop_front();
            compare("wb_wen", wb_wen, e.wen);
            compare("wb_ale", wb_ale, e.ale);
            compare("wb_ertn", wb_ertn, e.ertn);
            if (e.chk_result) begin
                compare("wb_result", wb_result, e.result);
            end
            compare("mem_req", mem_req, e.mem && !e.ale);
            if (e.mem && !e.ale) begin
                compare("mem_we", mem_we, e.we);
                compare("mem_addr", mem_addr, e.addr);
                compare("mem_sz", mem_sz, e.sz);
                compare("mem_wstrb", mem_wstrb, e.strb);
                if (e.we) begin
                    compare("mem_wdata", mem_wdata, e.wdata);
                end
            end
        end
    endtask

    // test 6 mixes the instruction groups of tests 1 to 5
    task automatic gen_instr(input int test_id, input int n);
        int grp;
        int off;
        grp = (test_id == 6) ? 1 + rand_below(5) : test_id;
        src_a     = pick_operand(grp == 2 || grp == 3);
        src_b     = pick_operand(grp == 2 || grp == 3);
        st_data   = lcg_next();
        pc        = lcg_next() & ~32'h3;
        u12imm    = 20'(lcg_next());
        access_sz = ACCESS_SZ_WORD;
        case (grp)
            1: op = ALU_OPS[rand_below(16)];
            2: op = MUL_OPS[rand_below(3)];
            3: begin
                op = DIV_OPS[rand_below(4)];
                // signed overflow case
                if (n % 10 == 0) begin
                    src_a = 32'h8000_0000;
                    src_b = 32'hffff_ffff;
                end
            end
            default: begin
                if (grp == 5 && rand_below(4) == 0) begin
                    op = (rand_below(2) == 0) ? OP_ERTN : OP_CACOP;
                end else begin
                    op = MEM_OPS[rand_below(5)];
                end
                if (op inside {OP_LD, OP_LDU, OP_ST}) begin
                    access_sz = access_sz_t'(rand_below(3));
                end
                off = rand_below(4);
                if (grp == 4) begin
                    off = (access_sz == ACCESS_SZ_HALF) ? (off & 2) : off;
                    off = (access_sz == ACCESS_SZ_WORD) ? 0 : off;
                end
                src_b[1:0] = 2'(off) - src_a[1:0];
            end
        endcase
        op_type = class_of(op);
        if (grp == 1 && op_type == OP_TYPE_3R && rand_below(8) == 0) begin
            op_type = (rand_below(2) == 0) ? OP_TYPE_CSR : OP_TYPE_RDCNT;
        end
    endtask

    task automatic run_test(input int test_id, input string name);
        int          accepted;
        int          retired;
        int          errs_at_start;
        bit          pending;
        logic [31:0] r;
        accepted      = 0;
        retired       = 0;
        pending       = 1'b0;
        errs_at_start = errors;
        while (accepted < N_INSTR || exp_q.size() != 0) begin
            @(negedge clk);
            if (!pending && accepted < N_INSTR) begin
                gen_instr(test_id, accepted);
                pending = 1'b1;
            end
            r = lcg_next();
            issue_valid = pending && (test_id != 6 || r[31:30] != 2'b00);
            mem_ready   = (test_id != 6) || r[29];
            #(CLK_PERIOD / 10);
            if (wb_valid) begin
                retired++;
                check_retire();
            end
            if (issue_valid && issue_allow) begin
                exp_q.push_back(model_wb(op, op_type, access_sz, src_a, src_b, st_data, pc,
                                         u12imm));
                accepted++;
                pending = 1'b0;
            end
        end
        if (retired != accepted) begin
            errors++;
            $display("test %0d: %0d instructions accepted but %0d writebacks seen",
                     test_id, accepted, retired);
        end
        total_instr += accepted;
        $display("test %0d %s: %0d issued, %0d retired, %0d errors",
                 test_id, name, accepted, retired, errors - errs_at_start);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * N_INSTR * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", N_TESTS * N_INSTR * 40);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        op          = OP_ADD;
        op_type     = OP_TYPE_3R;
        access_sz   = ACCESS_SZ_WORD;
        src_a       = '0;
        src_b       = '0;
        st_data     = '0;
        pc          = '0;
        u12imm      = '0;
        mem_ready   = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(CLK_PERIOD / 10);
        compare("issue_allow", issue_allow, 32'd0);
        compare("mem_req", mem_req, 32'd0);
        compare("wb_valid", wb_valid, 32'd0);
        run_test(1, "alu and immediate results");
        run_test(2, "multiply");
        run_test(3, "divide");
        run_test(4, "aligned loads and stores");
        run_test(5, "misaligned accesses and ertn");
        run_test(6, "random mem_ready back to back");
        // pipeline drained, nothing may retire any more
        repeat (8) begin
            @(negedge clk);
            #(CLK_PERIOD / 10);
            if (wb_valid) begin
                errors++;
                $display("writeback at %0t after all instructions retired", $time);
            end
        end
        $display("summary: %0d tests, %0d instructions, %0d errors",
                 N_TESTS, total_instr, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
common/ex_pkg.sv
common/ex_mm_if.sv
execute/ex_alu.sv
execute/ex_muldiv.sv
execute/ex_ctrl.sv
rtl/ex_mm_reg.sv
rtl/mem_req.sv
rtl/ex_top.sv
test/ex_assertions.sv
test/ex_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - common/ex_pkg.sv
      - common/ex_mm_if.sv
      - execute/ex_alu.sv
      - execute/ex_muldiv.sv
      - execute/ex_ctrl.sv
      - rtl/ex_mm_reg.sv
      - rtl/mem_req.sv
      - rtl/ex_top.sv
  - target: test
    files:
      - test/ex_assertions.sv
      - test/ex_tb.sv
